// File: build.f
src/legacyDemodPkg.sv
src/modeCtrlIf.sv
src/demodRegisters.sv
src/symbolRouter.sv
src/dacRouter.sv
src/legacyDemodTop.sv
verification/legacyDemodTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f build.f \
    --top-module legacyDemodTb --Mdir obj_dir -o legacyDemodSim
./obj_dir/legacyDemodSim | tee sim.log
if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src/dacRouter.sv
//**********************************************************
// DAC channel router
// Picks the legacy or multi-h sample, keeps its upper
// 14 bits and holds them between sync pulses
//**********************************************************

module dacRouter
    import legacyDemodPkg::*;
(
    input  logic                clk,
    input  logic                clockCounterEn,
    modeCtrlIf.datapath         ctrl,
    input  dacSampleT           demodData,
    input  logic                demodSync,
    input  dacSampleT           multihData,
    input  logic                multihSync,
    input  logic                multihEn,
    output logic [dacWidth-1:0] dacData
);

    logic      useMultih;
    dacSampleT selSample;
    logic      selSync;

    // Multi-h loop owns the channel only when it asks for it
    assign useMultih = ctrl.multihSel && multihEn;

    //******************************************************
    // Stage 1, source select
    //******************************************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn || ctrl.datapathReset) begin
            selSample <= '0;
            selSync   <= 1'b0;
        end else if (useMultih) begin
            selSample <= multihData;
            selSync   <= multihSync;
        end else begin
            selSample <= demodData;
            selSync   <= demodSync;
        end
    end

    //******************************************************
    // Stage 2, hold the code until the next sync
    //******************************************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn || ctrl.datapathReset) begin
            dacData <= '0;
        end else if (selSync) begin
            // Low fraction bits are dropped
            dacData <= selSample.fields.dacCode;
        end
    end

endmodule

// File: src/demodRegisters.sv
//**********************************************************
// Demodulator control registers
// AXI4-Lite slave holding the mode, version word, free
// running cycle counter and the datapath soft reset
//**********************************************************

module demodRegisters
    import legacyDemodPkg::*;
(
    input  logic                    clk,
    input  logic                    clockCounterEn,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [axiAddrWidth-1:0] awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [axiDataWidth-1:0] wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [axiAddrWidth-1:0] araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [axiDataWidth-1:0] rdata,
    output logic [1:0]              rresp,
    output logic [modeWidth-1:0]    demodMode,
    modeCtrlIf.regs                 ctrl
);

    logic                       writeAccept;
    logic                       readAccept;
    logic                       writeOk;
    logic                       readOk;
    logic [axiDataWidth-1:0]    readWord;
    logic [axiDataWidth-1:0]    clockCounter;
    logic [resetCountWidth-1:0] resetCount;

    // Address and data must arrive together, one response outstanding
    assign writeAccept = awvalid && wvalid && !bvalid;
    assign awready     = writeAccept;
    assign wready      = writeAccept;
    assign readAccept  = arvalid && !rvalid;
    assign arready     = readAccept;

    assign writeOk = awaddr inside {regVersion, regMode, regClock, regReset};

    always_comb begin
        readOk   = 1'b1;
        readWord = '0;
        case (araddr)
            regVersion: readWord = versionNumber;
            regMode:    readWord = axiDataWidth'(demodMode);
            regClock:   readWord = clockCounter;
            regReset:   readWord = '0;
            default:    readOk   = 1'b0;
        endcase
    end

    //******************************************************
    // Response channels
    //******************************************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            bvalid <= 1'b0;
            bresp  <= axiRespOkay;
        end else if (writeAccept) begin
            bvalid <= 1'b1;
            bresp  <= writeOk ? axiRespOkay : axiRespSlvErr;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= axiRespOkay;
        end else if (readAccept) begin
            rvalid <= 1'b1;
            rdata  <= readWord;
            rresp  <= readOk ? axiRespOkay : axiRespSlvErr;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    //******************************************************
    // Mode, cycle counter and soft reset
    //******************************************************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode    <= '0;
            clockCounter <= '0;
            resetCount   <= '0;
        end else begin
            if (writeAccept && awaddr == regMode) begin
                demodMode <= wdata[modeWidth-1:0];
            end
            // Free running, restarted by software
            if (writeAccept && awaddr == regClock) begin
                clockCounter <= '0;
            end else begin
                clockCounter <= clockCounter + 1'b1;
            end
            if (writeAccept && awaddr == regReset) begin
                resetCount <= resetCountWidth'(softResetCycles);
            end else if (resetCount != '0) begin
                resetCount <= resetCount - 1'b1;
            end
        end
    end

    // Mode decode for the datapath
    assign ctrl.multihSel     = (demodMode == modeMultih);
    assign ctrl.invertI       = (demodMode == modeFm) || (demodMode == mode2fsk);
    assign ctrl.auSelect      = (demodMode == modeAuqpsk);
    assign ctrl.datapathReset = (resetCount != '0);

endmodule

// File: src/legacyDemodPkg.sv
//**********************************************************
// Legacy demodulator glue definitions
// Stream and DAC widths, mode codes, AXI4-Lite register
// map and the DAC sample layout
//**********************************************************

package legacyDemodPkg;

    // Datapath widths
    localparam int symWidth     = 18;
    localparam int dacWidth     = 14;
    localparam int dacFracWidth = 4;
    localparam int modeWidth    = 5;

    // Demodulation modes
    localparam logic [modeWidth-1:0] modeBpsk       = 5'd0;
    localparam logic [modeWidth-1:0] modeQpsk       = 5'd1;
    localparam logic [modeWidth-1:0] modeAuqpsk     = 5'd3;
    localparam logic [modeWidth-1:0] modeFm         = 5'd8;
    localparam logic [modeWidth-1:0] mode2fsk       = 5'd9;
    localparam logic [modeWidth-1:0] modeMultih     = 5'd12;
    localparam logic [modeWidth-1:0] modePcmTrellis = 5'd13;

    //******************************************************
    // AXI4-Lite register map
    //******************************************************
    localparam int axiAddrWidth = 4;
    localparam int axiDataWidth = 32;

    localparam logic [1:0] axiRespOkay   = 2'd0;
    localparam logic [1:0] axiRespSlvErr = 2'd2;

    localparam logic [axiAddrWidth-1:0] regVersion = 4'h0;
    localparam logic [axiAddrWidth-1:0] regMode    = 4'h4;
    localparam logic [axiAddrWidth-1:0] regClock   = 4'h8;
    localparam logic [axiAddrWidth-1:0] regReset   = 4'hC;

    localparam logic [axiDataWidth-1:0] versionNumber = 32'h0000_017D;

    // Soft reset pulse length in clocks
    localparam int softResetCycles = 6;
    localparam int resetCountWidth = $clog2(softResetCycles + 1);

    // DAC sample, raw or split into code and dropped fraction
    typedef struct packed {
        logic [dacWidth-1:0]     dacCode;
        logic [dacFracWidth-1:0] frac;
    } dacFieldsT;

    typedef union packed {
        logic [symWidth-1:0] raw;
        dacFieldsT           fields;
    } dacSampleT;

endpackage

// File: src/legacyDemodTop.sv
//**********************************************************
// Legacy demodulator glue, top level
// Register block, trellis and bit routing and three
// DAC channels
//**********************************************************

module legacyDemodTop
    import legacyDemodPkg::*;
(
    input  logic                    clk,
    input  logic                    clockCounterEn,
    // AXI4-Lite slave
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [axiAddrWidth-1:0] awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [axiDataWidth-1:0] wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [axiAddrWidth-1:0] araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [axiDataWidth-1:0] rdata,
    output logic [1:0]              rresp,
    output logic [modeWidth-1:0]    demodMode,
    // Legacy demodulator streams
    input  logic                    trellisSymSync,
    input  logic                    iSym2xEn,
    input  logic                    iSymEn,
    input  logic [symWidth-1:0]     iSymData,
    input  logic [symWidth-1:0]     qSymData,
    input  logic                    iBit,
    input  logic                    qBit,
    input  logic                    auBit,
    // Multi-h carrier loop streams
    input  logic                    multihLoopEn,
    input  logic                    multihLoop2xEn,
    input  logic [symWidth-1:0]     iMultihLoop,
    input  logic [symWidth-1:0]     qMultihLoop,
    output logic                    trellisSymEn,
    output logic                    trellisSym2xEn,
    output logic [symWidth-1:0]     iTrellis,
    output logic [symWidth-1:0]     qTrellis,
    output logic                    iData,
    output logic                    qData,
    output logic                    dataSymEn,
    output logic                    dataSym2xEn,
    // DAC channels
    input  logic [symWidth-1:0]     demod0Data,
    input  logic                    demod0Sync,
    input  logic [symWidth-1:0]     multihDac0Data,
    input  logic                    multihDac0Sync,
    input  logic                    multihDac0En,
    output logic [dacWidth-1:0]     dac0_d,
    input  logic [symWidth-1:0]     demod1Data,
    input  logic                    demod1Sync,
    input  logic [symWidth-1:0]     multihDac1Data,
    input  logic                    multihDac1Sync,
    input  logic                    multihDac1En,
    output logic [dacWidth-1:0]     dac1_d,
    input  logic [symWidth-1:0]     demod2Data,
    input  logic                    demod2Sync,
    input  logic [symWidth-1:0]     multihDac2Data,
    input  logic                    multihDac2Sync,
    input  logic                    multihDac2En,
    output logic [dacWidth-1:0]     dac2_d
);

    modeCtrlIf modeCtrl ();

    demodRegisters u_regs (
        .clk(clk), .clockCounterEn(clockCounterEn),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .demodMode(demodMode), .ctrl(modeCtrl)
    );

    symbolRouter u_symbols (
        .clk(clk), .clockCounterEn(clockCounterEn), .ctrl(modeCtrl),
        .trellisSymSync(trellisSymSync), .iSym2xEn(iSym2xEn), .iSymEn(iSymEn),
        .iSymData(iSymData), .qSymData(qSymData),
        .iBit(iBit), .qBit(qBit), .auBit(auBit),
        .multihLoopEn(multihLoopEn), .multihLoop2xEn(multihLoop2xEn),
        .iMultihLoop(iMultihLoop), .qMultihLoop(qMultihLoop),
        .trellisSymEn(trellisSymEn), .trellisSym2xEn(trellisSym2xEn),
        .iTrellis(iTrellis), .qTrellis(qTrellis),
        .iData(iData), .qData(qData),
        .dataSymEn(dataSymEn), .dataSym2xEn(dataSym2xEn)
    );

    dacRouter u_dac0 (
        .clk(clk), .clockCounterEn(clockCounterEn), .ctrl(modeCtrl),
        .demodData(demod0Data), .demodSync(demod0Sync),
        .multihData(multihDac0Data), .multihSync(multihDac0Sync),
        .multihEn(multihDac0En), .dacData(dac0_d)
    );

    dacRouter u_dac1 (
        .clk(clk), .clockCounterEn(clockCounterEn), .ctrl(modeCtrl),
        .demodData(demod1Data), .demodSync(demod1Sync),
        .multihData(multihDac1Data), .multihSync(multihDac1Sync),
        .multihEn(multihDac1En), .dacData(dac1_d)
    );

    dacRouter u_dac2 (
        .clk(clk), .clockCounterEn(clockCounterEn), .ctrl(modeCtrl),
        .demodData(demod2Data), .demodSync(demod2Sync),
        .multihData(multihDac2Data), .multihSync(multihDac2Sync),
        .multihEn(multihDac2En), .dacData(dac2_d)
    );

endmodule

// File: src/modeCtrlIf.sv
//**********************************************************
// Mode control bundle
// Decoded mode flags and soft reset from the register
// block to the symbol and DAC routers
//**********************************************************

interface modeCtrlIf;

    // Mode flags
    logic multihSel;
    logic invertI;
    logic auSelect;

    // Output datapath soft reset
    logic datapathReset;

    modport regs (
        output multihSel, invertI, auSelect, datapathReset
    );

    modport datapath (
        input  multihSel, invertI, auSelect, datapathReset
    );

endinterface

// File: src/symbolRouter.sv
//**********************************************************
// Symbol router
// Selects the trellis stream source and forms the
// registered data bit outputs
//**********************************************************

module symbolRouter
    import legacyDemodPkg::*;
(
    input  logic                clk,
    input  logic                clockCounterEn,
    modeCtrlIf.datapath         ctrl,
    input  logic                trellisSymSync,
    input  logic                iSym2xEn,
    input  logic                iSymEn,
    input  logic [symWidth-1:0] iSymData,
    input  logic [symWidth-1:0] qSymData,
    input  logic                iBit,
    input  logic                qBit,
    input  logic                auBit,
    input  logic                multihLoopEn,
    input  logic                multihLoop2xEn,
    input  logic [symWidth-1:0] iMultihLoop,
    input  logic [symWidth-1:0] qMultihLoop,
    output logic                trellisSymEn,
    output logic                trellisSym2xEn,
    output logic [symWidth-1:0] iTrellis,
    output logic [symWidth-1:0] qTrellis,
    output logic                iData,
    output logic                qData,
    output logic                dataSymEn,
    output logic                dataSym2xEn
);

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn || ctrl.datapathReset) begin
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
            iTrellis       <= '0;
            qTrellis       <= '0;
            iData          <= 1'b0;
            qData          <= 1'b0;
            dataSymEn      <= 1'b0;
            dataSym2xEn    <= 1'b0;
        end else begin
            // Trellis decoder fed from the multi-h loop in that mode
            trellisSymEn   <= ctrl.multihSel ? multihLoopEn : trellisSymSync;
            trellisSym2xEn <= ctrl.multihSel ? multihLoop2xEn : iSym2xEn;
            iTrellis       <= ctrl.multihSel ? iMultihLoop : iSymData;
            qTrellis       <= ctrl.multihSel ? qMultihLoop : qSymData;
            // FM style modes come out of the discriminator inverted
            iData          <= ctrl.invertI ? ~iBit : iBit;
            qData          <= ctrl.auSelect ? auBit : qBit;
            dataSymEn      <= iSymEn;
            dataSym2xEn    <= iSym2xEn;
        end
    end

endmodule

// File: verification/legacyDemodTb.sv
//**********************************************************
// Legacy demodulator glue testbench
// AXI4-Lite register checks, random stream stimulus and
// a cycle by cycle reference model of the routers
//**********************************************************

module legacyDemodTb
    import legacyDemodPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cycleLimit = 3000;
    localparam int symOutWidth = 2 * symWidth + 6;
    localparam logic [axiAddrWidth-1:0] unknownOffset = 4'h6;

    logic clk = 1'b0;
    logic clockCounterEn;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [axiAddrWidth-1:0] awaddr, araddr;
    logic [axiDataWidth-1:0] wdata, rdata;
    logic [1:0] bresp, rresp;
    logic [modeWidth-1:0] demodMode;
    logic trellisSymSync, iSym2xEn, iSymEn, iBit, qBit, auBit, multihLoopEn, multihLoop2xEn;
    logic [symWidth-1:0] iSymData, qSymData, iMultihLoop, qMultihLoop;
    logic trellisSymEn, trellisSym2xEn, iData, qData, dataSymEn, dataSym2xEn;
    logic [symWidth-1:0] iTrellis, qTrellis;
    // DAC channels 0 to 2
    logic [symWidth-1:0] demodData [3];
    logic [symWidth-1:0] multihData [3];
    logic demodSync [3];
    logic multihSync [3];
    logic multihEn [3];
    logic [dacWidth-1:0] dacOut [3];

    // Reference model state
    logic [modeWidth-1:0] modelMode;
    int modelResetCount;
    logic [symOutWidth-1:0] expSymbols;
    logic [symWidth-1:0] selSample [3];
    logic selSync [3];
    logic [dacWidth-1:0] expDac [3];

    logic [15:0] lfsr = 16'd66;
    int compareErrors = 0;
    int sequenceErrors = 0;
    int cycleCount = 0;

    always #4 clk = ~clk;

    legacyDemodTop u_dut (
        .*,
        .demod0Data(demodData[0]), .demod0Sync(demodSync[0]),
        .multihDac0Data(multihData[0]), .multihDac0Sync(multihSync[0]),
        .multihDac0En(multihEn[0]), .dac0_d(dacOut[0]),
        .demod1Data(demodData[1]), .demod1Sync(demodSync[1]),
        .multihDac1Data(multihData[1]), .multihDac1Sync(multihSync[1]),
        .multihDac1En(multihEn[1]), .dac1_d(dacOut[1]),
        .demod2Data(demodData[2]), .demod2Sync(demodSync[2]),
        .multihDac2Data(multihData[2]), .multihDac2Sync(multihSync[2]),
        .multihDac2En(multihEn[2]), .dac2_d(dacOut[2])
    );

    task automatic checkValue(input string what, input logic [63:0] got,
                              input logic [63:0] expected, inout int errors);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // Galois LFSR stepped once per output bit
    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [symWidth-1:0] randomSample();
        logic [symWidth-1:0] word;
        word = '0;
        repeat (symWidth) begin
            word = {word[symWidth-2:0], stepLfsr()};
        end
        return word;
    endfunction

    // Expected symbol router outputs for the current inputs
    function automatic logic [symOutWidth-1:0] expectSymbols(input logic [modeWidth-1:0] mode,
                                                             input logic softReset);
        logic multih;
        logic invert;
        multih = (mode == modeMultih);
        invert = (mode == modeFm) || (mode == mode2fsk);
        if (softReset) begin
            return '0;
        end
        return {multih ? multihLoopEn : trellisSymSync, multih ? multihLoop2xEn : iSym2xEn,
                multih ? iMultihLoop : iSymData, multih ? qMultihLoop : qSymData,
                invert ? !iBit : iBit, (mode == modeAuqpsk) ? auBit : qBit, iSymEn, iSym2xEn};
    endfunction

    //**********************************************************
    // Compare against the model on every rising edge
    //**********************************************************
    always @(posedge clk) begin
        if (clockCounterEn) begin
            modelMode = '0;
            modelResetCount = 0;
            expSymbols = '0;
            for (int n = 0; n < 3; n++) begin
                selSample[n] = '0;
                selSync[n] = 1'b0;
                expDac[n] = '0;
            end
        end else begin
            checkValue("demodMode", 64'(demodMode), 64'(modelMode), compareErrors);
            checkValue("symbol outputs", 64'({trellisSymEn, trellisSym2xEn, iTrellis, qTrellis,
                       iData, qData, dataSymEn, dataSym2xEn}), 64'(expSymbols), compareErrors);
            for (int n = 0; n < 3; n++) begin
                checkValue($sformatf("dac%0d", n), 64'(dacOut[n]), 64'(expDac[n]), compareErrors);
            end
            expSymbols = expectSymbols(modelMode, modelResetCount != 0);
            for (int n = 0; n < 3; n++) begin
                if (modelResetCount != 0) begin
                    expDac[n] = '0;
                    selSample[n] = '0;
                    selSync[n] = 1'b0;
                end else begin
                    // Upper 14 bits of the sample picked up one clock earlier
                    if (selSync[n]) begin
                        expDac[n] = selSample[n][symWidth-1 -: dacWidth];
                    end
                    selSample[n] = (modelMode == modeMultih && multihEn[n]) ?
                                   multihData[n] : demodData[n];
                    selSync[n] = (modelMode == modeMultih && multihEn[n]) ?
                                 multihSync[n] : demodSync[n];
                end
            end
            if (awvalid && awready && awaddr == regMode) begin
                modelMode = wdata[modeWidth-1:0];
            end
            if (awvalid && awready && awaddr == regReset) begin
                modelResetCount = softResetCycles;
            end else if (modelResetCount != 0) begin
                modelResetCount--;
            end
        end
    end

    task automatic driveRandom(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            trellisSymSync = stepLfsr();
            iSym2xEn = stepLfsr();
            iSymEn = stepLfsr();
            iBit = stepLfsr();
            qBit = stepLfsr();
            auBit = stepLfsr();
            multihLoopEn = stepLfsr();
            multihLoop2xEn = stepLfsr();
            iSymData = randomSample();
            qSymData = randomSample();
            iMultihLoop = randomSample();
            qMultihLoop = randomSample();
            for (int n = 0; n < 3; n++) begin
                demodData[n] = randomSample();
                demodSync[n] = stepLfsr();
                multihData[n] = randomSample();
                multihSync[n] = stepLfsr();
                multihEn[n] = stepLfsr();
            end
        end
    endtask

    //**********************************************************
    // AXI4-Lite master tasks
    //**********************************************************
    task automatic axiWrite(input logic [axiAddrWidth-1:0] addr,
                            input logic [axiDataWidth-1:0] data,
                            input int stall, output logic [1:0] resp);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid = 1'b1;
        awaddr = addr;
        wdata = data;
        bready = (stall == 0);
        do @(posedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        if (stall > 0) begin
            // A second write offered while the response is held
            awvalid = 1'b1;
            wvalid = 1'b1;
            wdata = ~data;
            repeat (stall) begin
                @(posedge clk);
                checkValue("awready with bvalid held", 64'(awready), 64'(0), sequenceErrors);
                checkValue("wready with bvalid held", 64'(wready), 64'(0), sequenceErrors);
            end
            @(negedge clk);
            awvalid = 1'b0;
            wvalid = 1'b0;
            bready = 1'b1;
        end
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [axiAddrWidth-1:0] addr,
                           output logic [axiDataWidth-1:0] data,
                           output logic [1:0] resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr = addr;
        rready = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        logic [axiDataWidth-1:0] data;
        logic [axiDataWidth-1:0] firstCount;
        logic [1:0] resp;
        logic [modeWidth-1:0] modeList [7];
        modeList = '{modeBpsk, modeQpsk, modeAuqpsk, modeFm, mode2fsk, modeMultih,
                     modePcmTrellis};
        clockCounterEn = 1'b1;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        {trellisSymSync, iSym2xEn, iSymEn, iBit, qBit, auBit, multihLoopEn, multihLoop2xEn} = '0;
        {iSymData, qSymData, iMultihLoop, qMultihLoop} = '0;
        for (int n = 0; n < 3; n++) begin
            demodData[n] = '0;
            multihData[n] = '0;
            demodSync[n] = 1'b0;
            multihSync[n] = 1'b0;
            multihEn[n] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        clockCounterEn = 1'b0;

        // Version word and unknown offset
        axiRead(regVersion, data, resp);
        checkValue("version word", 64'(data), 64'(versionNumber), sequenceErrors);
        checkValue("version resp", 64'(resp), 64'(axiRespOkay), sequenceErrors);
        axiRead(unknownOffset, data, resp);
        checkValue("unknown read data", 64'(data), 64'(0), sequenceErrors);
        checkValue("unknown read resp", 64'(resp), 64'(axiRespSlvErr), sequenceErrors);
        axiWrite(unknownOffset, 32'h1F, 0, resp);
        checkValue("unknown write resp", 64'(resp), 64'(axiRespSlvErr), sequenceErrors);
        axiRead(regMode, data, resp);
        checkValue("mode after unknown write", 64'(data), 64'(0), sequenceErrors);

        // Every mode in turn with the FM write response stalled
        for (int m = 0; m < 7; m++) begin
            axiWrite(regMode, 32'(modeList[m]), (modeList[m] == modeFm) ? 5 : 0, resp);
            checkValue("mode write resp", 64'(resp), 64'(axiRespOkay), sequenceErrors);
            axiRead(regMode, data, resp);
            checkValue("mode readback", 64'(data), 64'(modeList[m]), sequenceErrors);
            driveRandom(200);
        end

        // Soft reset clears the outputs while the streams keep running
        axiWrite(regReset, 32'h1, 0, resp);
        repeat (4) begin
            driveRandom(1);
            @(posedge clk);
            checkValue("symbol outputs in soft reset", 64'({trellisSymEn, trellisSym2xEn,
                       iTrellis, qTrellis, iData, qData, dataSymEn, dataSym2xEn}), 64'(0),
                       sequenceErrors);
            checkValue("dac0 in soft reset", 64'(dacOut[0]), 64'(0), sequenceErrors);
            checkValue("dac1 in soft reset", 64'(dacOut[1]), 64'(0), sequenceErrors);
            checkValue("dac2 in soft reset", 64'(dacOut[2]), 64'(0), sequenceErrors);
        end
        driveRandom(40);

        // Cycle counter restart and two samples 20 cycles apart
        axiWrite(regClock, 32'h0, 0, resp);
        axiRead(regClock, firstCount, resp);
        // Cleared at write acceptance, read accepted two clocks after the response
        checkValue("clock counter after restart", 64'(firstCount), 64'(2), sequenceErrors);
        repeat (20) @(posedge clk);
        axiRead(regClock, data, resp);
        checkValue("clock counter step", 64'((data > firstCount) && (data - firstCount >= 20)),
                   64'(1), sequenceErrors);

        $display("run complete, %0d stream errors, %0d register errors",
                 compareErrors, sequenceErrors);
        if (compareErrors + sequenceErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout, the test sequence did not finish within %0d cycles", cycleLimit);
        $display("%0d stream errors, %0d register errors", compareErrors, sequenceErrors);
        $display("Test FAILED");
        $finish;
    end

endmodule
